// File: src/cache_bus_pkg.sv
/* bus widths and the request struct for the CPU and memory ports;
   shared by the cache top level, datapath and testbench */

`default_nettype none

package cache_bus_pkg;

    // line address, one address per 128-bit line
    localparam int ADDR_W = 12;
    localparam int LINE_W = 128;
    // one select per byte of the line
    localparam int SEL_W = LINE_W / 8;

    // one wishbone request as the CPU presents it
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [SEL_W-1:0]  sel;
        logic [LINE_W-1:0] dat;
        logic              we;
    } bus_req_t;

endpackage

`default_nettype wire

// File: src/cache_ctrl_pkg.sv
/* controller states and the control strobes sent to the datapath */

`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL,
        RESPOND
    } ctrl_state_e;

    // strobes from controller to datapath
    typedef struct packed {
        logic data_src;   // 0 cpu data and selects, 1 memory line
        logic tag_bypass; // 0 victim tag, 1 request tag
        logic load;
        logic load_lru;
    } dp_ctrl_t;

endpackage

`default_nettype wire

// File: src/cache_way.sv
/* one cache way: per-set valid, dirty, tag and line storage with tag compare;
   cpu loads merge enabled bytes, memory loads replace the line */

`default_nettype none

module cache_way #(
    parameter int NUM_LINES = 8,
    localparam int IDX_W = $clog2(NUM_LINES),
    localparam int TAG_W = cache_bus_pkg::ADDR_W - IDX_W
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic                            load_type,
    input  logic [cache_bus_pkg::SEL_W-1:0] byte_sel,
    input  logic [TAG_W-1:0]                tag_in,
    input  logic [IDX_W-1:0]                index,
    input  logic [cache_bus_pkg::LINE_W-1:0] data_in,
    output logic [cache_bus_pkg::LINE_W-1:0] data_out,
    output logic [TAG_W-1:0]                tag_out,
    output logic                            dirty_out,
    output logic                            hit_out
);

    logic [NUM_LINES-1:0]              valid;
    logic [NUM_LINES-1:0]              dirty;
    logic [TAG_W-1:0]                  tags  [NUM_LINES];
    logic [cache_bus_pkg::LINE_W-1:0]  lines [NUM_LINES];
    logic [cache_bus_pkg::LINE_W-1:0]  merged;

    // byte merge of new data over the stored line
    always_comb begin
        for (int b = 0; b < cache_bus_pkg::SEL_W; b++) begin
            merged[b*8 +: 8] = byte_sel[b] ? data_in[b*8 +: 8] : lines[index][b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (load) begin
            if (load_type) begin
                // fresh line from memory
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;
            end else begin
                dirty[index] <= 1'b1;
            end
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (load) begin
            tags[index]  <= tag_in;
            lines[index] <= merged;
        end
    end

    assign data_out  = lines[index];
    assign tag_out   = tags[index];
    assign dirty_out = dirty[index];
    assign hit_out   = valid[index] && (tags[index] == tag_in);

endmodule

`default_nettype wire

// File: src/cache_lru.sv
/* per-set recency lists; entry 0 is most recent, the last entry is the
   replacement victim reported on lru_out */

`default_nettype none

module cache_lru #(
    parameter int NUM_LINES = 8,
    parameter int ASSOCIATIVITY = 2,
    localparam int IDX_W = $clog2(NUM_LINES),
    localparam int WAY_W = $clog2(ASSOCIATIVITY)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WAY_W-1:0] mru_in,
    input  logic [IDX_W-1:0] index_in,
    input  logic             load_in,
    output logic [WAY_W-1:0] lru_out
);

    logic [ASSOCIATIVITY-1:0][WAY_W-1:0] order [NUM_LINES];
    logic [ASSOCIATIVITY-1:0][WAY_W-1:0] next_order;
    logic                                perm_ok;

    // move mru_in to the front, entries ahead of it slide back one
    always_comb begin
        int pos;
        pos = 0;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (order[index_in][i] == mru_in) begin
                pos = i;
            end
        end
        next_order[0] = mru_in;
        for (int i = 1; i < ASSOCIATIVITY; i++) begin
            next_order[i] = (i <= pos) ? order[index_in][i-1] : order[index_in][i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_LINES; s++) begin
                for (int i = 0; i < ASSOCIATIVITY; i++) begin
                    order[s][i] <= WAY_W'(i);
                end
            end
        end else if (load_in) begin
            order[index_in] <= next_order;
        end
    end

    assign lru_out = order[index_in][ASSOCIATIVITY-1];

    // every way appears exactly once in each set
    always_comb begin
        logic [ASSOCIATIVITY-1:0] seen_ways;
        perm_ok = 1'b1;
        for (int s = 0; s < NUM_LINES; s++) begin
            seen_ways = '0;
            for (int i = 0; i < ASSOCIATIVITY; i++) begin
                seen_ways[order[s][i]] = 1'b1;
            end
            if (seen_ways != '1) begin
                perm_ok = 1'b0;
            end
        end
    end

    a_lru_perm : assert property (@(posedge clk) disable iff (rst) perm_ok)
        else $error("lru order is not a permutation");

endmodule

`default_nettype wire

// File: src/cache_datapath.sv
/* cache datapath: write source muxes, way array, read muxes, LRU and
   memory address forming; driven by the controller strobes */

`default_nettype none

module cache_datapath #(
    parameter int NUM_LINES = 8,
    parameter int ASSOCIATIVITY = 2,
    localparam int WAY_W = $clog2(ASSOCIATIVITY)
) (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_ctrl_pkg::dp_ctrl_t         ctrl,
    input  logic [WAY_W-1:0]                 way_sel,
    input  cache_bus_pkg::bus_req_t          cpu_req,
    input  logic [cache_bus_pkg::LINE_W-1:0] mem_dat_r,
    output logic [ASSOCIATIVITY-1:0]         hit,
    output logic                             dirty,
    output logic [WAY_W-1:0]                 lru,
    output logic [cache_bus_pkg::LINE_W-1:0] cpu_dat,
    output logic [cache_bus_pkg::ADDR_W-1:0] mem_adr,
    output logic [cache_bus_pkg::LINE_W-1:0] mem_dat_w
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = cache_bus_pkg::ADDR_W - IDX_W;

    logic [TAG_W-1:0]                                    req_tag;
    logic [IDX_W-1:0]                                    index;
    logic [cache_bus_pkg::LINE_W-1:0]                    wr_data;
    logic [cache_bus_pkg::SEL_W-1:0]                     wr_sel;
    logic [ASSOCIATIVITY-1:0]                            way_load;
    logic [ASSOCIATIVITY-1:0][cache_bus_pkg::LINE_W-1:0] way_data;
    logic [ASSOCIATIVITY-1:0][TAG_W-1:0]                 way_tag;
    logic [ASSOCIATIVITY-1:0]                            way_dirty;
    logic [TAG_W-1:0]                                    victim_tag;
    logic [cache_bus_pkg::LINE_W-1:0]                    sel_data;

    // address split, index in the low bits
    assign req_tag = cpu_req.adr[cache_bus_pkg::ADDR_W-1:IDX_W];
    assign index   = cpu_req.adr[IDX_W-1:0];

    // write source: cpu bytes or a whole memory line
    assign wr_data = ctrl.data_src ? mem_dat_r : cpu_req.dat;
    assign wr_sel  = ctrl.data_src ? '1 : cpu_req.sel;

    // steer load to the selected way only
    always_comb begin
        way_load          = '0;
        way_load[way_sel] = ctrl.load;
    end

    for (genvar w = 0; w < ASSOCIATIVITY; w++) begin : g_way
        cache_way #(
            .NUM_LINES(NUM_LINES)
        ) u_way (
            .clk      (clk),
            .rst      (rst),
            .load     (way_load[w]),
            .load_type(ctrl.data_src),
            .byte_sel (wr_sel),
            .tag_in   (req_tag),
            .index    (index),
            .data_in  (wr_data),
            .data_out (way_data[w]),
            .tag_out  (way_tag[w]),
            .dirty_out(way_dirty[w]),
            .hit_out  (hit[w])
        );
    end

    cache_lru #(
        .NUM_LINES    (NUM_LINES),
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) u_lru (
        .clk     (clk),
        .rst     (rst),
        .mru_in  (way_sel),
        .index_in(index),
        .load_in (ctrl.load_lru),
        .lru_out (lru)
    );

    // selected way feeds both the cpu and the write-back path
    assign sel_data  = way_data[way_sel];
    assign cpu_dat   = sel_data;
    assign mem_dat_w = sel_data;

    // victim tag for write-back, request tag for fill
    assign victim_tag = way_tag[way_sel];
    assign mem_adr    = {ctrl.tag_bypass ? req_tag : victim_tag, index};

    assign dirty = way_dirty[lru];

    a_hit_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
        else $error("tag matched in more than one way");

endmodule

`default_nettype wire

// File: src/cache_controller.sv
/* cache controller FSM: tag compare, dirty write-back, line fill and the
   cpu acknowledge; drives the datapath strobes and the memory bus */

`default_nettype none

module cache_controller #(
    parameter int ASSOCIATIVITY = 2,
    localparam int WAY_W = $clog2(ASSOCIATIVITY)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_cyc,
    input  logic                     cpu_stb,
    input  logic                     cpu_we,
    input  logic [ASSOCIATIVITY-1:0] hit,
    input  logic                     dirty,
    input  logic [WAY_W-1:0]         lru,
    input  logic                     mem_ack,
    output cache_ctrl_pkg::dp_ctrl_t ctrl,
    output logic [WAY_W-1:0]         way_sel,
    output logic                     cpu_ack,
    output logic                     mem_cyc,
    output logic                     mem_stb,
    output logic                     mem_we
);

    cache_ctrl_pkg::ctrl_state_e state;
    cache_ctrl_pkg::ctrl_state_e next_state;
    logic                        hit_any;
    logic [WAY_W-1:0]            hit_way;
    logic [WAY_W-1:0]            victim;

    assign hit_any = |hit;

    // encode the matching way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_ctrl_pkg::IDLE: begin
                if (cpu_cyc && cpu_stb) begin
                    next_state = cache_ctrl_pkg::COMPARE;
                end
            end
            cache_ctrl_pkg::COMPARE: begin
                if (hit_any) begin
                    next_state = cache_ctrl_pkg::RESPOND;
                end else if (dirty) begin
                    next_state = cache_ctrl_pkg::WRITEBACK;
                end else begin
                    next_state = cache_ctrl_pkg::FILL;
                end
            end
            cache_ctrl_pkg::WRITEBACK: begin
                if (mem_ack) begin
                    next_state = cache_ctrl_pkg::FILL;
                end
            end
            cache_ctrl_pkg::FILL: begin
                // back to compare, which now hits
                if (mem_ack) begin
                    next_state = cache_ctrl_pkg::COMPARE;
                end
            end
            default: next_state = cache_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_ctrl_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // victim way held from the miss until the fill lands
    always_ff @(posedge clk) begin
        if (state == cache_ctrl_pkg::COMPARE && !hit_any) begin
            victim <= lru;
        end
    end

    assign way_sel = (state == cache_ctrl_pkg::WRITEBACK || state == cache_ctrl_pkg::FILL)
                     ? victim : hit_way;

    // datapath strobes
    assign ctrl.data_src   = (state == cache_ctrl_pkg::FILL);
    assign ctrl.tag_bypass = (state == cache_ctrl_pkg::FILL);
    assign ctrl.load       = (state == cache_ctrl_pkg::COMPARE && hit_any && cpu_we)
                             || (state == cache_ctrl_pkg::FILL && mem_ack);
    assign ctrl.load_lru   = (state == cache_ctrl_pkg::COMPARE) && hit_any;

    // bus strobes
    assign cpu_ack = (state == cache_ctrl_pkg::RESPOND);
    assign mem_cyc = (state == cache_ctrl_pkg::WRITEBACK) || (state == cache_ctrl_pkg::FILL);
    assign mem_stb = mem_cyc;
    assign mem_we  = (state == cache_ctrl_pkg::WRITEBACK);

    // the refilled victim way must hit on the following compare
    a_fill_hits : assert property (@(posedge clk) disable iff (rst)
        (state == cache_ctrl_pkg::FILL && mem_ack) |=> hit[victim])
        else $error("no hit in the filled way after a line fill");

endmodule

`default_nettype wire

// File: src/cache_top.sv
/* write-back set-associative cache between a CPU wishbone port and a memory
   wishbone port; joins the controller and the datapath */

`default_nettype none

module cache_top #(
    parameter int NUM_LINES = 8,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic                             rst,
    // cpu side
    input  logic                             cpu_cyc,
    input  logic                             cpu_stb,
    input  cache_bus_pkg::bus_req_t          cpu_req,
    output logic [cache_bus_pkg::LINE_W-1:0] cpu_dat,
    output logic                             cpu_ack,
    // memory side
    output logic                             mem_cyc,
    output logic                             mem_stb,
    output logic                             mem_we,
    output logic [cache_bus_pkg::ADDR_W-1:0] mem_adr,
    output logic [cache_bus_pkg::SEL_W-1:0]  mem_sel,
    output logic [cache_bus_pkg::LINE_W-1:0] mem_dat_w,
    input  logic [cache_bus_pkg::LINE_W-1:0] mem_dat_r,
    input  logic                             mem_ack
);

    cache_ctrl_pkg::dp_ctrl_t           ctrl;
    logic [$clog2(ASSOCIATIVITY)-1:0]   way_sel;
    logic [$clog2(ASSOCIATIVITY)-1:0]   lru;
    logic [ASSOCIATIVITY-1:0]           hit;
    logic                               dirty;

    // memory traffic is always whole lines
    assign mem_sel = '1;

    cache_controller #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .cpu_cyc(cpu_cyc),
        .cpu_stb(cpu_stb),
        .cpu_we (cpu_req.we),
        .hit    (hit),
        .dirty  (dirty),
        .lru    (lru),
        .mem_ack(mem_ack),
        .ctrl   (ctrl),
        .way_sel(way_sel),
        .cpu_ack(cpu_ack),
        .mem_cyc(mem_cyc),
        .mem_stb(mem_stb),
        .mem_we (mem_we)
    );

    cache_datapath #(
        .NUM_LINES    (NUM_LINES),
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) u_dp (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .way_sel  (way_sel),
        .cpu_req  (cpu_req),
        .mem_dat_r(mem_dat_r),
        .hit      (hit),
        .dirty    (dirty),
        .lru      (lru),
        .cpu_dat  (cpu_dat),
        .mem_adr  (mem_adr),
        .mem_dat_w(mem_dat_w)
    );

endmodule

`default_nettype wire

// File: verification/cache_tb.sv
/* testbench for the write-back cache: memory slave with random wait cycles,
   shadow copy of cpu-visible lines, directed hit, miss, write-back and LRU tests */

`default_nettype none

module cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_W      = cache_bus_pkg::LINE_W;
    localparam int ADDR_W      = cache_bus_pkg::ADDR_W;
    localparam int SEL_W       = cache_bus_pkg::SEL_W;
    localparam int ACK_TIMEOUT = 200;
    // idle samples the request, compare hits, respond acks
    localparam int HIT_LATENCY = 2;

    // index is the low 3 bits with 8 sets
    localparam logic [ADDR_W-1:0] ADR_A  = 12'h013;
    localparam logic [ADDR_W-1:0] ADR_V0 = 12'h02d;
    localparam logic [ADDR_W-1:0] ADR_V1 = 12'h035;
    localparam logic [ADDR_W-1:0] ADR_V2 = 12'h03d;
    localparam logic [ADDR_W-1:0] ADR_LA = 12'h016;
    localparam logic [ADDR_W-1:0] ADR_LB = 12'h01e;
    localparam logic [ADDR_W-1:0] ADR_LC = 12'h026;

    logic                    clk;
    logic                    rst;
    logic                    cpu_cyc;
    logic                    cpu_stb;
    cache_bus_pkg::bus_req_t cpu_req;
    logic [LINE_W-1:0]       cpu_dat;
    logic                    cpu_ack;
    logic                    mem_cyc;
    logic                    mem_stb;
    logic                    mem_we;
    logic [ADDR_W-1:0]       mem_adr;
    logic [SEL_W-1:0]        mem_sel;
    logic [LINE_W-1:0]       mem_dat_w;
    logic [LINE_W-1:0]       mem_dat_r;
    logic                    mem_ack;

    logic [LINE_W-1:0] mem    [2**ADDR_W];
    logic [LINE_W-1:0] shadow [2**ADDR_W];

    // log of completed memory transactions
    int                rd_count;
    int                wb_count;
    logic [ADDR_W-1:0] last_rd_adr;
    logic [ADDR_W-1:0] last_wb_adr;
    logic [LINE_W-1:0] last_wb_dat;
    logic [SEL_W-1:0]  last_wb_sel;

    int    errors;
    int    test_mark;
    int    tests_run;
    int    tests_failed;
    string test_name;

    cache_top uut (
        .clk      (clk),
        .rst      (rst),
        .cpu_cyc  (cpu_cyc),
        .cpu_stb  (cpu_stb),
        .cpu_req  (cpu_req),
        .cpu_dat  (cpu_dat),
        .cpu_ack  (cpu_ack),
        .mem_cyc  (mem_cyc),
        .mem_stb  (mem_stb),
        .mem_we   (mem_we),
        .mem_adr  (mem_adr),
        .mem_sel  (mem_sel),
        .mem_dat_w(mem_dat_w),
        .mem_dat_r(mem_dat_r),
        .mem_ack  (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [LINE_W-1:0] random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // wishbone memory slave, 0 to 3 wait cycles per request
    initial begin : memory_model
        int   delay;
        logic busy;
        delay     = 0;
        busy      = 1'b0;
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        rd_count  = 0;
        wb_count  = 0;
        forever begin
            @(negedge clk);
            if (mem_ack) begin
                mem_ack   = 1'b0;
                mem_dat_r = random_line();
            end else if (!rst && mem_cyc && mem_stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom_range(3, 0);
                end
                if (delay > 0) begin
                    delay--;
                end else begin
                    busy    = 1'b0;
                    mem_ack = 1'b1;
                    if (mem_we) begin
                        mem[mem_adr] = mem_dat_w;
                        last_wb_adr  = mem_adr;
                        last_wb_dat  = mem_dat_w;
                        last_wb_sel  = mem_sel;
                        wb_count++;
                    end else begin
                        mem_dat_r   = mem[mem_adr];
                        last_rd_adr = mem_adr;
                        rd_count++;
                    end
                end
            end
        end
    end

    a_mem_sel : assert property (@(posedge clk) disable iff (rst) mem_cyc |-> mem_sel == '1)
        else begin
            $display("Error: memory request without all byte selects");
            errors++;
        end

    a_mem_stb : assert property (@(posedge clk) disable iff (rst) mem_stb |-> mem_cyc)
        else begin
            $display("Error: memory strobe outside a bus cycle");
            errors++;
        end

    task automatic check_line(input logic [LINE_W-1:0] expected,
                              input logic [LINE_W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_num(input int expected, input int actual);
        assert (actual == expected)
        else begin
            $display("Mismatch in %s: expected %0d, actual %0d", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else begin
            $display("Error in %s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_mark) begin
            tests_failed++;
            $display("FAIL %s", test_name);
        end else begin
            $display("PASS %s", test_name);
        end
    endtask

    task automatic finish_run();
        $display("Tests run: %0d, failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // one cpu request held until ack, counted in falling edges
    task automatic cpu_access(input logic [ADDR_W-1:0] adr, input logic we,
                              input logic [SEL_W-1:0] sel, input logic [LINE_W-1:0] dat,
                              output logic [LINE_W-1:0] rdata, output int cycles,
                              output logic mem_seen);
        int waited;
        @(negedge clk);
        cpu_req.adr = adr;
        cpu_req.we  = we;
        cpu_req.sel = sel;
        cpu_req.dat = dat;
        cpu_cyc     = 1'b1;
        cpu_stb     = 1'b1;
        waited      = 0;
        mem_seen    = 1'b0;
        rdata       = '0;
        do begin
            @(negedge clk);
            waited++;
            if (mem_cyc) begin
                mem_seen = 1'b1;
            end
        end while (!cpu_ack && waited < ACK_TIMEOUT);
        cycles = waited;
        if (!cpu_ack) begin
            errors++;
            $display("Error in %s: no cpu ack within %0d cycles", test_name, ACK_TIMEOUT);
        end else begin
            rdata = cpu_dat;
        end
        // idle would take a request still held at the next edge
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] adr, output int cycles,
                              output logic mem_seen);
        logic [LINE_W-1:0] rdata;
        cpu_access(adr, 1'b0, '0, '0, rdata, cycles, mem_seen);
        check_line(shadow[adr], rdata);
    endtask

    task automatic write_line(input logic [ADDR_W-1:0] adr, input logic [SEL_W-1:0] sel,
                              input logic [LINE_W-1:0] dat);
        logic [LINE_W-1:0] rdata;
        int                cycles;
        logic              mem_seen;
        cpu_access(adr, 1'b1, sel, dat, rdata, cycles, mem_seen);
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                shadow[adr][b*8 +: 8] = dat[b*8 +: 8];
            end
        end
    endtask

    initial begin : stimulus
        int   cycles;
        int   rd_before;
        int   wb_before;
        logic mem_seen;
        logic quiet;
        void'($urandom(32'h9d8f));
        errors       = 0;
        test_mark    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "";
        rst          = 1'b1;
        cpu_cyc      = 1'b0;
        cpu_stb      = 1'b0;
        cpu_req      = '0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem[a]    = random_line();
            shadow[a] = mem[a];
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_idle");
        quiet = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (cpu_ack || mem_cyc) begin
                quiet = 1'b0;
            end
        end
        check_true(quiet, "cpu_ack or mem_cyc high before any request");
        end_test();

        start_test("read_miss");
        rd_before = rd_count;
        read_check(ADR_A, cycles, mem_seen);
        check_num(rd_before + 1, rd_count);
        check_num(int'(ADR_A), int'(last_rd_adr));
        end_test();

        start_test("read_hit");
        read_check(ADR_A, cycles, mem_seen);
        check_num(HIT_LATENCY, cycles);
        check_true(!mem_seen, "memory cycle during a read hit");
        end_test();

        start_test("write_merge");
        write_line(ADR_A, SEL_W'($urandom), random_line());
        read_check(ADR_A, cycles, mem_seen);
        check_true(!mem_seen, "memory cycle while reading a written line");
        end_test();

        // two dirty lines fill set 5, the older one is the victim
        start_test("writeback");
        write_line(ADR_V0, SEL_W'($urandom), random_line());
        write_line(ADR_V1, SEL_W'($urandom), random_line());
        wb_before = wb_count;
        rd_before = rd_count;
        read_check(ADR_V2, cycles, mem_seen);
        check_num(wb_before + 1, wb_count);
        check_num(int'(ADR_V0), int'(last_wb_adr));
        check_line(shadow[ADR_V0], last_wb_dat);
        check_num((1 << SEL_W) - 1, int'(last_wb_sel));
        check_num(rd_before + 1, rd_count);
        end_test();

        // A, B, A in set 6, then C replaces B
        start_test("lru_order");
        read_check(ADR_LA, cycles, mem_seen);
        read_check(ADR_LB, cycles, mem_seen);
        read_check(ADR_LA, cycles, mem_seen);
        check_true(!mem_seen, "second read of A missed");
        wb_before = wb_count;
        read_check(ADR_LC, cycles, mem_seen);
        check_num(wb_before, wb_count);
        read_check(ADR_LA, cycles, mem_seen);
        check_true(!mem_seen, "A was evicted instead of B");
        rd_before = rd_count;
        read_check(ADR_LB, cycles, mem_seen);
        check_true(mem_seen, "B still cached after C was filled");
        check_num(rd_before + 1, rd_count);
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire

// File: cache_top.f
src/cache_bus_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_way.sv
src/cache_lru.sv
src/cache_datapath.sv
src/cache_controller.sv
src/cache_top.sv
verification/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
